// ==== verif/dcache_tests.txt ====
# columns: op (0 read, 1 write, 2 invalidate), byte address, write data, expected read data, expect miss
# memory starts as word address ^ 5a5a0000; expected read data only checked on reads
0 00000000 00000000 5a5a0000 1
0 00000008 00000000 5a5a0002 0
0 00001014 00000000 5a5a0405 1
0 00001014 00000000 5a5a0405 0
0 0000101c 00000000 5a5a0407 0
0 00001010 00000000 5a5a0404 0
1 00001018 deadbeef 00000000 0
0 00001018 00000000 deadbeef 0
1 00002020 12345678 00000000 0
0 00002020 00000000 12345678 1
0 00002024 00000000 5a5a0809 0
# set 3, three lines, lru eviction
0 00003030 00000000 5a5a0c0c 1
0 00004034 00000000 5a5a100d 1
0 00003038 00000000 5a5a0c0e 0
0 0000503c 00000000 5a5a140f 1
0 00003030 00000000 5a5a0c0c 0
0 00004030 00000000 5a5a100c 1
0 00005030 00000000 5a5a140c 1
0 00004038 00000000 5a5a100e 0
0 00003034 00000000 5a5a0c0d 1
0 00005034 00000000 5a5a140d 1
# invalidate set 1
2 00001010 00000000 00000000 0
0 00001018 00000000 deadbeef 1
0 00001014 00000000 5a5a0405 0
# write hit in set 3, then invalidate the set
1 00005034 cafef00d 00000000 0
0 00005034 00000000 cafef00d 0
2 00005030 00000000 00000000 0
0 00005034 00000000 cafef00d 1
0 00003030 00000000 5a5a0c0c 1
# write miss does not allocate
1 0000f0f0 0badc0de 00000000 0
0 0000f0f4 00000000 5a5a3c3d 1
0 0000f0f0 00000000 0badc0de 0

// ==== vlog.f ====
design/dcache_pkg.sv
design/dcache_bram.sv
design/dcache_tagv.sv
design/dcache_data.sv
design/dcache_req_stage.sv
design/dcache_miss_ctrl.sv
design/dcache_top.sv
verif/dcache_tb.sv

// ==== Makefile ====
SRCS := $(filter-out +%,$(shell cat vlog.f))
BIN  := obj_dir/Vdcache_tb

.PHONY: all run clean

all: run

$(BIN): vlog.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module dcache_tb \
		-Mdir obj_dir -f vlog.f

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
		echo "$$out" | grep -q '^Regression passed$$'

clean:
	rm -rf obj_dir

// ==== verif/dcache_tb.sv ====
`timescale 1ns/1ps

module dcache_tb import dcache_pkg::*; ();

    localparam int cycles_per_test = 200;
    // quiet cycles checked before the first request
    localparam int idle_cycles     = 8;

    logic              clk;
    logic              rst_n;
    logic              cpu_req;
    dcache_op_e        cpu_op;
    logic [addr_w-1:0] cpu_addr;
    logic [data_w-1:0] cpu_wdata;
    logic              cpu_ack;
    logic [data_w-1:0] cpu_rdata;
    logic              mem_req;
    logic              mem_we;
    logic [addr_w-1:0] mem_addr;
    logic [data_w-1:0] mem_wdata;
    logic              mem_ack;
    logic [data_w-1:0] mem_rdata;

    // test vectors, one entry per file line
    logic [31:0] t_op[$];
    logic [31:0] t_addr[$];
    logic [31:0] t_wdata[$];
    logic [31:0] t_rdata[$];
    logic [31:0] t_miss[$];
    int          n_tests;
    bit          tests_loaded;

    // memory traffic of the current request
    logic [31:0] rd_addrs[$];
    logic [31:0] wr_addrs[$];
    logic [31:0] wr_datas[$];

    // words written so far, everything else is the fill pattern
    logic [31:0] mem_model [logic [29:0]];
    integer      seed = 32'h9913_5422;

    int data_errs;
    int mem_errs;
    int other_errs;

    dcache_top #(.index_w(4)) u_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .cpu_req  (cpu_req),
        .cpu_op   (cpu_op),
        .cpu_addr (cpu_addr),
        .cpu_wdata(cpu_wdata),
        .cpu_ack  (cpu_ack),
        .cpu_rdata(cpu_rdata),
        .mem_req  (mem_req),
        .mem_we   (mem_we),
        .mem_addr (mem_addr),
        .mem_wdata(mem_wdata),
        .mem_ack  (mem_ack),
        .mem_rdata(mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////////////////////////
    // memory model
    ////////////////////////////////////////

    // untouched words hold word address ^ 5a5a0000
    function automatic logic [31:0] mem_word(input logic [29:0] waddr);
        if (mem_model.exists(waddr)) begin
            return mem_model[waddr];
        end
        return {2'b00, waddr} ^ 32'h5a5a_0000;
    endfunction

    initial begin : mem_responder
        int          delay;
        logic [31:0] req_addr;
        mem_ack   = 1'b0;
        mem_rdata = '0;
        forever begin
            @(negedge clk);
            if (rst_n && mem_req) begin
                req_addr = mem_addr;
                // 0 to 3 cycles of back-pressure
                delay = $random(seed) & 3;
                repeat (delay) @(negedge clk);
                assert (mem_addr === req_addr) else begin
                    other_errs++;
                    $display("Mismatch mem_addr not held: got %h expected %h",
                             mem_addr, req_addr);
                end
                if (mem_we) begin
                    mem_model[mem_addr[31:2]] = mem_wdata;
                    wr_addrs.push_back(mem_addr);
                    wr_datas.push_back(mem_wdata);
                end else begin
                    rd_addrs.push_back(mem_addr);
                end
                mem_rdata = mem_word(mem_addr[31:2]);
                mem_ack   = 1'b1;
                // ack stays up until req drops
                do begin
                    @(negedge clk);
                end while (mem_req);
                mem_ack = 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // test file and cpu driver
    ////////////////////////////////////////

    task automatic load_tests;
        int          fd;
        string       line;
        logic [31:0] f_op;
        logic [31:0] f_addr;
        logic [31:0] f_wdata;
        logic [31:0] f_rdata;
        logic [31:0] f_miss;
        fd = $fopen("verif/dcache_tests.txt", "r");
        if (fd == 0) begin
            other_errs++;
            $display("cannot open verif/dcache_tests.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                // comment lines start with #
                if (line.len() > 1 && line[0] != "#") begin
                    if ($sscanf(line, "%h %h %h %h %h",
                                f_op, f_addr, f_wdata, f_rdata, f_miss) == 5) begin
                        t_op.push_back(f_op);
                        t_addr.push_back(f_addr);
                        t_wdata.push_back(f_wdata);
                        t_rdata.push_back(f_rdata);
                        t_miss.push_back(f_miss);
                    end
                end
            end
            $fclose(fd);
        end
        n_tests = t_op.size();
        if (n_tests == 0) begin
            other_errs++;
            $display("no test lines found in the test file");
        end
        tests_loaded = 1'b1;
    endtask

    // no request yet, so both handshakes stay quiet
    task automatic check_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            assert (!cpu_ack && !mem_req) else begin
                other_errs++;
                $display("cpu_ack or mem_req went high with no request pending");
            end
        end
    endtask

    task automatic run_test(input int idx);
        logic [1:0]  op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] exp_rdata;
        logic        exp_miss;
        logic [3:0]  seen;
        int          exp_reads;
        op        = t_op[idx][1:0];
        addr      = t_addr[idx];
        wdata     = t_wdata[idx];
        exp_rdata = t_rdata[idx];
        exp_miss  = t_miss[idx][0];
        // a read miss fetches the whole line
        exp_reads = (op == op_read && exp_miss) ? 4 : 0;
        rd_addrs.delete();
        wr_addrs.delete();
        wr_datas.delete();

        @(negedge clk);
        cpu_req   = 1'b1;
        cpu_op    = dcache_op_e'(op);
        cpu_addr  = addr;
        cpu_wdata = wdata;
        do begin
            @(negedge clk);
        end while (!cpu_ack);
        if (op == op_read) begin
            assert (cpu_rdata === exp_rdata) else begin
                data_errs++;
                $display("Mismatch test %0d addr %h: cpu_rdata got %h expected %h",
                         idx, addr, cpu_rdata, exp_rdata);
            end
        end
        cpu_req = 1'b0;
        do begin
            @(negedge clk);
        end while (cpu_ack);

        assert (rd_addrs.size() == exp_reads) else begin
            mem_errs++;
            $display("test %0d addr %h: expected %0d memory reads but saw %0d",
                     idx, addr, exp_reads, rd_addrs.size());
        end
        if (exp_reads == 4) begin
            seen = '0;
            foreach (rd_addrs[i]) begin
                if (rd_addrs[i][31:4] == addr[31:4] && rd_addrs[i][1:0] == 2'b00) begin
                    seen[rd_addrs[i][3:2]] = 1'b1;
                end
            end
            assert (seen == 4'hf) else begin
                mem_errs++;
                $display("test %0d addr %h: refill did not fetch every word of the line",
                         idx, addr);
            end
        end
        if (op == op_write) begin
            assert (wr_addrs.size() == 1) else begin
                mem_errs++;
                $display("test %0d addr %h: expected one memory write but saw %0d",
                         idx, addr, wr_addrs.size());
            end
            if (wr_addrs.size() == 1) begin
                assert (wr_addrs[0] == {addr[31:2], 2'b00}) else begin
                    mem_errs++;
                    $display("Mismatch test %0d: mem_addr got %h expected %h",
                             idx, wr_addrs[0], {addr[31:2], 2'b00});
                end
                assert (wr_datas[0] == wdata) else begin
                    mem_errs++;
                    $display("Mismatch test %0d: mem_wdata got %h expected %h",
                             idx, wr_datas[0], wdata);
                end
            end
        end else begin
            assert (wr_addrs.size() == 0) else begin
                mem_errs++;
                $display("test %0d addr %h: memory write on a read or invalidate",
                         idx, addr);
            end
        end
    endtask

    task automatic print_summary;
        $display("tests %0d, data errors %0d, memory errors %0d, other errors %0d",
                 n_tests, data_errs, mem_errs, other_errs);
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        rst_n     = 1'b0;
        cpu_req   = 1'b0;
        cpu_op    = op_read;
        cpu_addr  = '0;
        cpu_wdata = '0;
        data_errs  = 0;
        mem_errs   = 0;
        other_errs = 0;
        load_tests();
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        // first request lands inside the init sweep
        check_idle(idle_cycles);
        for (int i = 0; i < n_tests; i++) begin
            run_test(i);
        end
        print_summary();
        if (data_errs + mem_errs + other_errs == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // run length scales with the number of test lines
    initial begin : watchdog
        wait (tests_loaded);
        repeat ((n_tests + 1) * cycles_per_test) @(posedge clk);
        $display("timeout after %0d cycles, the cache stopped answering",
                 (n_tests + 1) * cycles_per_test);
        print_summary();
        $display("Regression failed");
        $finish;
    end

endmodule

// ==== design/dcache_top.sv ====
`timescale 1ns/1ps

module dcache_top import dcache_pkg::*; #(
    parameter int index_w = 4,
    localparam int tag_w = addr_w - index_w - line_words_w - 2
) (
    input  logic              clk,
    input  logic              rst_n,
    // cpu port
    input  logic              cpu_req,
    input  dcache_op_e        cpu_op,
    input  logic [addr_w-1:0] cpu_addr,
    input  logic [data_w-1:0] cpu_wdata,
    output logic              cpu_ack,
    output logic [data_w-1:0] cpu_rdata,
    // memory port
    output logic              mem_req,
    output logic              mem_we,
    output logic [addr_w-1:0] mem_addr,
    output logic [data_w-1:0] mem_wdata,
    input  logic              mem_ack,
    input  logic [data_w-1:0] mem_rdata
);

    // captured request
    logic                            go;
    logic                            done;
    dcache_op_e                      rq_op;
    logic [tag_w-1:0]                rq_tag;
    logic [index_w-1:0]              rq_index;
    logic [line_words_w-1:0]         rq_word;
    logic [data_w-1:0]               rq_wdata;
    logic [data_w-1:0]               rword;

    // array results
    logic [1:0]                      hit;
    logic [1:0]                      valid;
    logic [data_w-1:0]               hit_word;

    // array updates
    logic [index_w-1:0]              tv_waddr;
    logic [tag_w-1:0]                tv_wtag;
    logic [1:0]                      tv_we;
    logic [1:0]                      tv_inval;
    logic                            tv_clear;
    logic [index_w+line_words_w-1:0] d_waddr;
    logic [index_w+line_words_w-1:0] d_raddr;
    logic [data_w-1:0]               d_wdata;
    logic [1:0]                      d_we;

    // refill position while a fill word is written
    assign d_raddr = (|d_we) ? d_waddr : {rq_index, rq_word};

    dcache_req_stage #(.index_w(index_w)) u_req (
        .clk(clk), .rst_n(rst_n),
        .cpu_req(cpu_req), .cpu_op(cpu_op), .cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata),
        .cpu_ack(cpu_ack), .cpu_rdata(cpu_rdata),
        .go(go), .op(rq_op), .tag(rq_tag), .index(rq_index), .word(rq_word),
        .wdata(rq_wdata), .done(done), .rword(rword)
    );

    dcache_tagv #(.index_w(index_w)) u_tagv (
        .clk(clk), .raddr(rq_index), .cmp_tag(rq_tag), .hit(hit), .valid(valid),
        .waddr(tv_waddr), .wtag(tv_wtag), .we(tv_we), .inval(tv_inval), .clear(tv_clear)
    );

    dcache_data #(.index_w(index_w)) u_data (
        .clk(clk), .raddr(d_raddr), .waddr(d_waddr), .wdata(d_wdata), .we(d_we),
        .hit(hit), .rdata(hit_word)
    );

    dcache_miss_ctrl #(.index_w(index_w)) u_ctrl (
        .clk(clk), .rst_n(rst_n),
        .go(go), .op(rq_op), .tag(rq_tag), .index(rq_index), .word(rq_word),
        .wdata(rq_wdata), .done(done), .rword(rword),
        .hit(hit), .valid(valid), .hit_word(hit_word),
        .tv_waddr(tv_waddr), .tv_wtag(tv_wtag), .tv_we(tv_we), .tv_inval(tv_inval),
        .tv_clear(tv_clear),
        .d_waddr(d_waddr), .d_wdata(d_wdata), .d_we(d_we),
        .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .mem_ack(mem_ack), .mem_rdata(mem_rdata)
    );

endmodule

// ==== design/dcache_miss_ctrl.sv ====
`timescale 1ns/1ps

module dcache_miss_ctrl import dcache_pkg::*; #(
    parameter int index_w = 4,
    localparam int tag_w = addr_w - index_w - line_words_w - 2
) (
    input  logic                            clk,
    input  logic                            rst_n,
    // captured request
    input  logic                            go,
    input  dcache_op_e                      op,
    input  logic [tag_w-1:0]                tag,
    input  logic [index_w-1:0]              index,
    input  logic [line_words_w-1:0]         word,
    input  logic [data_w-1:0]               wdata,
    output logic                            done,
    output logic [data_w-1:0]               rword,
    // array read results
    input  logic [1:0]                      hit,
    input  logic [1:0]                      valid,
    input  logic [data_w-1:0]               hit_word,
    // tag and valid updates
    output logic [index_w-1:0]              tv_waddr,
    output logic [tag_w-1:0]                tv_wtag,
    output logic [1:0]                      tv_we,
    output logic [1:0]                      tv_inval,
    output logic                            tv_clear,
    // data updates
    output logic [index_w+line_words_w-1:0] d_waddr,
    output logic [data_w-1:0]               d_wdata,
    output logic [1:0]                      d_we,
    // memory port
    output logic                            mem_req,
    output logic                            mem_we,
    output logic [addr_w-1:0]               mem_addr,
    output logic [data_w-1:0]               mem_wdata,
    input  logic                            mem_ack,
    input  logic [data_w-1:0]               mem_rdata
);

    ctrl_state_e             state;
    logic [index_w-1:0]      init_cnt;
    logic [line_words_w-1:0] fill_cnt;
    logic [line_words_w-1:0] fill_nxt;
    // per set, the way to evict next
    logic [(1<<index_w)-1:0] lru;
    // go seen during the init sweep
    logic                    pend;
    logic                    victim;
    logic                    pick;

    assign fill_nxt = fill_cnt + 1'b1;

    // first invalid way, then lru
    assign pick = !valid[0] ? 1'b0 : (!valid[1] ? 1'b1 : lru[index]);

    ////////////////////////////////////////
    // state and handshake
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= st_init;
            init_cnt <= '0;
            fill_cnt <= '0;
            lru      <= '0;
            pend     <= 1'b0;
            mem_req  <= 1'b0;
        end else begin
            if (go) begin
                pend <= 1'b1;
            end
            case (state)
                st_init: begin
                    init_cnt <= init_cnt + 1'b1;
                    if (&init_cnt) begin
                        state <= st_idle;
                    end
                end
                st_idle: begin
                    if (go || pend) begin
                        pend  <= 1'b0;
                        state <= st_lookup;
                    end
                end
                st_lookup: begin
                    if (op == op_write) begin
                        mem_req <= 1'b1;
                        state   <= st_wt_req;
                    end else if (op == op_read && !(|hit)) begin
                        fill_cnt <= '0;
                        mem_req  <= 1'b1;
                        state    <= st_refill_req;
                    end else begin
                        // read hit, the other way becomes lru
                        if (op == op_read) begin
                            lru[index] <= hit[0];
                        end
                        state <= st_respond;
                    end
                end
                st_refill_req: begin
                    if (mem_ack) begin
                        mem_req <= 1'b0;
                        state   <= st_refill_wait;
                    end
                end
                st_refill_wait: begin
                    // wait for the ack to fall
                    if (!mem_ack) begin
                        if (&fill_cnt) begin
                            state <= st_fill_end;
                        end else begin
                            fill_cnt <= fill_nxt;
                            mem_req  <= 1'b1;
                            state    <= st_refill_req;
                        end
                    end
                end
                st_fill_end: begin
                    lru[index] <= ~victim;
                    state      <= st_respond;
                end
                st_wt_req: begin
                    if (mem_ack) begin
                        mem_req <= 1'b0;
                        state   <= st_wt_wait;
                    end
                end
                st_wt_wait: begin
                    if (!mem_ack) begin
                        state <= st_respond;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // memory request fields and read word
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (state == st_lookup) begin
            victim    <= pick;
            mem_we    <= (op == op_write);
            mem_wdata <= wdata;
            // refill starts at word zero of the line
            if (op == op_write) begin
                mem_addr <= {tag, index, word, 2'b00};
            end else begin
                mem_addr <= {tag, index, {line_words_w{1'b0}}, 2'b00};
            end
            if (|hit) begin
                rword <= hit_word;
            end
        end
        if (state == st_refill_wait && !mem_ack) begin
            mem_addr <= {tag, index, fill_nxt, 2'b00};
        end
        // keep the requested word as it passes
        if (state == st_refill_req && mem_ack && fill_cnt == word) begin
            rword <= mem_rdata;
        end
    end

    ////////////////////////////////////////
    // array writes
    ////////////////////////////////////////

    always_comb begin
        tv_waddr = (state == st_init) ? init_cnt : index;
        tv_clear = (state == st_init);
        tv_we    = '0;
        tv_inval = '0;
        d_waddr  = {index, word};
        d_wdata  = wdata;
        d_we     = '0;
        case (state)
            st_lookup: begin
                // write hit updates the cached word only
                if (op == op_write) begin
                    d_we = hit;
                end
                if (op == op_inval) begin
                    tv_inval = 2'b11;
                end
            end
            st_refill_req: begin
                d_waddr = {index, fill_cnt};
                d_wdata = mem_rdata;
                if (mem_ack) begin
                    d_we = victim ? 2'b10 : 2'b01;
                end
            end
            st_fill_end: begin
                tv_we = victim ? 2'b10 : 2'b01;
            end
            default: begin
            end
        endcase
    end

    assign tv_wtag = tag;
    assign done    = (state == st_respond);

endmodule

// ==== design/dcache_req_stage.sv ====
`timescale 1ns/1ps

module dcache_req_stage import dcache_pkg::*; #(
    parameter int index_w = 4,
    localparam int tag_w = addr_w - index_w - line_words_w - 2
) (
    input  logic                    clk,
    input  logic                    rst_n,
    // cpu port
    input  logic                    cpu_req,
    input  dcache_op_e              cpu_op,
    input  logic [addr_w-1:0]       cpu_addr,
    input  logic [data_w-1:0]       cpu_wdata,
    output logic                    cpu_ack,
    output logic [data_w-1:0]       cpu_rdata,
    // to the resolve stage and the arrays
    output logic                    go,
    output dcache_op_e              op,
    output logic [tag_w-1:0]        tag,
    output logic [index_w-1:0]      index,
    output logic [line_words_w-1:0] word,
    output logic [data_w-1:0]       wdata,
    // back from the resolve stage
    input  logic                    done,
    input  logic [data_w-1:0]       rword
);

    logic req_q;
    logic take;

    // new request edge, never while the ack is still up
    assign take = cpu_req && !req_q && !cpu_ack;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_q   <= 1'b0;
            go      <= 1'b0;
            cpu_ack <= 1'b0;
        end else begin
            req_q <= cpu_req;
            go    <= take;
            // ack rises after done, falls once req is gone
            if (done) begin
                cpu_ack <= 1'b1;
            end else if (cpu_ack && !cpu_req) begin
                cpu_ack <= 1'b0;
            end
        end
    end

    // request fields, split once and held
    always_ff @(posedge clk) begin
        if (take) begin
            op    <= cpu_op;
            tag   <= cpu_addr[addr_w-1 -: tag_w];
            index <= cpu_addr[line_words_w+2 +: index_w];
            word  <= cpu_addr[2 +: line_words_w];
            wdata <= cpu_wdata;
        end
    end

    // read word held while ack is high
    always_ff @(posedge clk) begin
        if (done) begin
            cpu_rdata <= rword;
        end
    end

endmodule

// ==== design/dcache_data.sv ====
`timescale 1ns/1ps

module dcache_data import dcache_pkg::*; #(
    parameter int index_w = 4
) (
    input  logic                            clk,
    // index and word offset
    input  logic [index_w+line_words_w-1:0] raddr,
    input  logic [index_w+line_words_w-1:0] waddr,
    input  logic [data_w-1:0]               wdata,
    input  logic [1:0]                      we,
    // way select from the tag compare
    input  logic [1:0]                      hit,
    output logic [data_w-1:0]               rdata
);

    logic [data_w-1:0] way_q [2];

    // both ways read every cycle
    for (genvar w = 0; w < 2; w++) begin : g_way
        dcache_bram #(
            .data_width(data_w),
            .addr_width(index_w + line_words_w)
        ) u_mem (
            .clk  (clk),
            .waddr(waddr),
            .din  (wdata),
            .we   (we[w]),
            .raddr(raddr),
            .dout (way_q[w])
        );
    end

    // zero on a miss
    always_comb begin
        if (hit[0]) begin
            rdata = way_q[0];
        end else if (hit[1]) begin
            rdata = way_q[1];
        end else begin
            rdata = '0;
        end
    end

endmodule

// ==== design/dcache_tagv.sv ====
`timescale 1ns/1ps

module dcache_tagv import dcache_pkg::*; #(
    parameter int index_w = 4,
    localparam int tag_w = addr_w - index_w - line_words_w - 2
) (
    input  logic               clk,
    // lookup side
    input  logic [index_w-1:0] raddr,
    input  logic [tag_w-1:0]   cmp_tag,
    output logic [1:0]         hit,
    output logic [1:0]         valid,
    // update side, all at waddr
    input  logic [index_w-1:0] waddr,
    input  logic [tag_w-1:0]   wtag,
    input  logic [1:0]         we,
    input  logic [1:0]         inval,
    input  logic               clear
);

    // index of the read held by the tag memories
    logic [index_w-1:0] raddr_q;

    always_ff @(posedge clk) begin
        raddr_q <= raddr;
    end

    ////////////////////////////////////////
    // one tag memory and valid vector per way
    ////////////////////////////////////////

    for (genvar w = 0; w < 2; w++) begin : g_way
        logic [tag_w-1:0]          tag_q;
        logic [(1<<index_w)-1:0]   valid_q;

        // clear writes a zero tag as well
        dcache_bram #(
            .data_width(tag_w),
            .addr_width(index_w)
        ) u_tag (
            .clk  (clk),
            .waddr(waddr),
            .din  (clear ? '0 : wtag),
            .we   (we[w] | clear),
            .raddr(raddr),
            .dout (tag_q)
        );

        // clear and invalidate win over a fill
        always_ff @(posedge clk) begin
            if (clear || inval[w]) begin
                valid_q[waddr] <= 1'b0;
            end else if (we[w]) begin
                valid_q[waddr] <= 1'b1;
            end
        end

        // valid bit of the same index the tag came from
        assign valid[w] = valid_q[raddr_q];
        assign hit[w]   = valid[w] && (tag_q == cmp_tag);
    end

endmodule

// ==== design/dcache_bram.sv ====
`timescale 1ns/1ps

module dcache_bram #(
    parameter int data_width = 32,
    parameter int addr_width = 4
) (
    input  logic                  clk,
    // write port
    input  logic [addr_width-1:0] waddr,
    input  logic [data_width-1:0] din,
    input  logic                  we,
    // read port, one cycle latency
    input  logic [addr_width-1:0] raddr,
    output logic [data_width-1:0] dout
);

    // contents undefined at power up
    logic [data_width-1:0] mem [1 << addr_width];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= din;
        end
    end

    // old data on a same-address collision
    always_ff @(posedge clk) begin
        dout <= mem[raddr];
    end

endmodule

// ==== design/dcache_pkg.sv ====
package dcache_pkg;

    // byte address and data word widths
    localparam int addr_w = 32;
    localparam int data_w = 32;

    // four words per line
    localparam int line_words_w = 2;

    ////////////////////////////////////////
    // cpu side operations
    ////////////////////////////////////////

    typedef enum logic [1:0] {
        op_read  = 2'd0,
        op_write = 2'd1,
        // drop both ways of one set
        op_inval = 2'd2
    } dcache_op_e;

    ////////////////////////////////////////
    // resolve stage states
    ////////////////////////////////////////

    typedef enum logic [3:0] {
        // clear sweep after reset
        st_init,
        st_idle,
        // hit and valid are valid here
        st_lookup,
        // refill, one word per transaction
        st_refill_req,
        st_refill_wait,
        // write-through to memory
        st_wt_req,
        st_wt_wait,
        // tag and valid of the victim written here
        st_fill_end,
        // done to the request stage
        st_respond
    } ctrl_state_e;

endpackage
